// File: Bender.yml
package:
  name: lc3b_slice

sources:
  - files:
      - design/lc3b_types.sv
      - design/pipe_pkg.sv
      - design/control_rom.sv
      - design/decode_stage.sv
      - design/issue_queue.sv
      - design/execute_stage.sv
      - design/lc3b_slice.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/lc3b_slice_properties.sv
      - tests/lc3b_slice_tb.sv

// File: design/control_rom.sv
`timescale 1ns/1ns
`default_nettype none

module control_rom (
    input  lc3b_types::lc3b_opcode   opcode,
    // bit 5 of the word, also picks arithmetic right shift
    input  logic                     imm_check,
    input  logic                     rshf_check,
    output pipe_pkg::lc3b_control_word ctrl
);

    always_comb begin
        ctrl.opcode       = opcode;
        ctrl.aluop        = lc3b_types::alu_pass;
        ctrl.load_cc      = 1'b0;
        ctrl.load_regfile = 1'b0;
        ctrl.sr2mux_sel   = 1'b0;
        ctrl.mem_read     = 1'b0;
        ctrl.mem_write    = 1'b0;
        ctrl.drmux_sel    = 2'b00;

        case (opcode)
            lc3b_types::op_add: begin
                ctrl.aluop        = lc3b_types::alu_add;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.sr2mux_sel   = imm_check;
                ctrl.drmux_sel    = 2'b11;
            end

            lc3b_types::op_and: begin
                ctrl.aluop        = lc3b_types::alu_and;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.sr2mux_sel   = imm_check;
                ctrl.drmux_sel    = 2'b11;
            end

            lc3b_types::op_not: begin
                ctrl.aluop        = lc3b_types::alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.drmux_sel    = 2'b11;
            end

            lc3b_types::op_shf: begin
                if (!rshf_check) begin
                    ctrl.aluop = lc3b_types::alu_sll;
                end else if (!imm_check) begin
                    ctrl.aluop = lc3b_types::alu_srl;
                end else begin
                    ctrl.aluop = lc3b_types::alu_sra;
                end
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.drmux_sel    = 2'b11;
            end

            lc3b_types::op_ldr: begin
                ctrl.mem_read     = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.drmux_sel    = 2'b01;
            end

            // stores leave the condition codes alone
            lc3b_types::op_str: begin
                ctrl.mem_write = 1'b1;
            end

            // no pc in this slice, so these retire as no-ops
            lc3b_types::op_br, lc3b_types::op_trap, lc3b_types::op_jsr: begin
            end

            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  lc3b_types::lc3b_instr instr,
    input  logic                  instr_valid,
    output pipe_pkg::queue_entry  entry,
    output logic                  push
);

    lc3b_types::lc3b_instr      ir;
    pipe_pkg::lc3b_control_word ctrl;

    // push doubles as the valid flag of the instruction register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push <= 1'b0;
        end else begin
            push <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            ir <= instr;
        end
    end

    control_rom control_rom_i (
        .opcode     (ir.op.opcode),
        .imm_check  (ir.op.imm_flag),
        .rshf_check (ir.op.low[4]),
        .ctrl       (ctrl)
    );

    always_comb begin
        entry.ctrl   = ctrl;
        entry.dr     = ir.op.dr;
        entry.sr1    = ir.op.sr1;
        entry.sr2    = ir.op.low[2:0];
        entry.imm    = {{11{ir.op.low[4]}}, ir.op.low};
        entry.offset = {{9{ir.mem.offset6[5]}}, ir.mem.offset6, 1'b0};

        if (ctrl.mem_read || ctrl.mem_write) begin
            entry.sr1 = ir.mem.base;
        end
        // str reads its data register through the second read port
        if (ctrl.mem_write) begin
            entry.sr2 = ir.mem.dr_sr;
        end
    end

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  pipe_pkg::queue_entry head,
    input  logic                 not_empty,
    output logic                 pop,
    output logic                 wb_valid,
    output pipe_pkg::wb_port     wb,
    output logic [2:0]           cc
);

    lc3b_types::lc3b_word rf [8];
    lc3b_types::lc3b_word dmem [pipe_pkg::dmem_words];

    lc3b_types::lc3b_word sr1_val;
    lc3b_types::lc3b_word sr2_val;
    lc3b_types::lc3b_word opnd2;
    lc3b_types::lc3b_word alu_out;
    lc3b_types::lc3b_word addr_sum;
    logic [$clog2(pipe_pkg::dmem_words)-1:0] mem_idx;
    logic [3:0]       shamt;
    logic             ldr_wb;
    logic             ld_load_cc;
    pipe_pkg::wb_port ld_pend;
    pipe_pkg::wb_port wb_next;
    logic             alu_wb;
    logic             ld_start;
    logic             st_go;
    logic             wb_en;
    logic             cc_en;
    logic [2:0]       cc_next;

    // hold the queue while a load finishes its writeback cycle
    assign pop = not_empty && !ldr_wb;

    assign sr1_val  = rf[head.sr1];
    assign sr2_val  = rf[head.sr2];
    assign opnd2    = head.ctrl.sr2mux_sel ? head.imm : sr2_val;
    assign shamt    = head.imm[3:0];
    assign addr_sum = sr1_val + head.offset;
    assign mem_idx  = addr_sum[5:1];

    always_comb begin
        case (head.ctrl.aluop)
            lc3b_types::alu_add:  alu_out = sr1_val + opnd2;
            lc3b_types::alu_and:  alu_out = sr1_val & opnd2;
            lc3b_types::alu_not:  alu_out = ~sr1_val;
            lc3b_types::alu_sll:  alu_out = sr1_val << shamt;
            lc3b_types::alu_srl:  alu_out = sr1_val >> shamt;
            lc3b_types::alu_sra:  alu_out = $signed(sr1_val) >>> shamt;
            default:              alu_out = sr1_val;
        endcase
    end

    assign alu_wb   = pop && head.ctrl.load_regfile && (head.ctrl.drmux_sel == 2'b11);
    assign ld_start = pop && head.ctrl.mem_read;
    assign st_go    = pop && head.ctrl.mem_write;
    assign wb_en    = alu_wb || ldr_wb;

    always_comb begin
        if (ldr_wb) begin
            wb_next = ld_pend;
            cc_en   = ld_load_cc;
        end else begin
            wb_next.dr   = head.dr;
            wb_next.data = alu_out;
            cc_en        = head.ctrl.load_cc;
        end
    end

    // n z p
    assign cc_next = {wb_next.data[15],
                      wb_next.data == '0,
                      !wb_next.data[15] && (wb_next.data != '0)};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ldr_wb     <= 1'b0;
            ld_load_cc <= 1'b0;
            wb_valid   <= 1'b0;
            cc         <= 3'b000;
            for (int i = 0; i < 8; i++) begin
                rf[i] <= '0;
            end
        end else begin
            ldr_wb   <= ld_start;
            wb_valid <= wb_en;
            if (ld_start) begin
                ld_load_cc <= head.ctrl.load_cc;
            end
            if (wb_en) begin
                rf[wb_next.dr] <= wb_next.data;
                if (cc_en) begin
                    cc <= cc_next;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_en) begin
            wb <= wb_next;
        end
        if (ld_start) begin
            ld_pend.dr   <= head.dr;
            ld_pend.data <= dmem[mem_idx];
        end
        if (st_go) begin
            dmem[mem_idx] <= sr2_val;
        end
    end

endmodule

`default_nettype wire

// File: design/issue_queue.sv
`timescale 1ns/1ns
`default_nettype none

module issue_queue (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push,
    input  pipe_pkg::queue_entry entry_in,
    input  logic                 pop,
    output pipe_pkg::queue_entry head,
    output logic                 not_empty,
    output logic                 full
);

    pipe_pkg::queue_entry slots [pipe_pkg::queue_depth];

    logic [$clog2(pipe_pkg::queue_depth)-1:0] wr_ptr;
    logic [$clog2(pipe_pkg::queue_depth)-1:0] rd_ptr;
    logic [$clog2(pipe_pkg::queue_depth):0]   count;
    logic                                     do_push;
    logic                                     do_pop;

    assign not_empty = (count != '0);
    assign full      = (count == pipe_pkg::queue_depth);
    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;
    assign head      = slots[rd_ptr];

    // depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            slots[wr_ptr] <= entry_in;
        end
    end

endmodule

`default_nettype wire

// File: design/lc3b_slice.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_slice (
    input  logic                  clk,
    input  logic                  rst_n,
    input  lc3b_types::lc3b_instr instr,
    input  logic                  instr_valid,
    output logic                  full,
    output logic                  wb_valid,
    output pipe_pkg::wb_port      wb,
    output logic [2:0]            cc
);

    pipe_pkg::queue_entry dec_entry;
    pipe_pkg::queue_entry head;
    logic                 push;
    logic                 pop;
    logic                 not_empty;

    decode_stage decode_stage_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .entry       (dec_entry),
        .push        (push)
    );

    issue_queue issue_queue_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .entry_in  (dec_entry),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty),
        .full      (full)
    );

    execute_stage execute_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .head      (head),
        .not_empty (not_empty),
        .pop       (pop),
        .wb_valid  (wb_valid),
        .wb        (wb),
        .cc        (cc)
    );

endmodule

`default_nettype wire

// File: design/lc3b_types.sv
`default_nettype none

package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0] lc3b_reg;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass,
        alu_sll,
        alu_srl,
        alu_sra
    } lc3b_aluop;

    // operate format, low holds imm5, sr2 in [2:0], or shift dir/amount
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dr;
        lc3b_reg    sr1;
        logic       imm_flag;
        logic [4:0] low;
    } lc3b_op_fmt;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dr_sr;
        lc3b_reg    base;
        logic [5:0] offset6;
    } lc3b_mem_fmt;

    typedef union packed {
        lc3b_op_fmt  op;
        lc3b_mem_fmt mem;
    } lc3b_instr;

endpackage

`default_nettype wire

// File: design/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    localparam int queue_depth = 4;
    localparam int dmem_words = 32;

    typedef struct packed {
        lc3b_types::lc3b_opcode opcode;
        lc3b_types::lc3b_aluop  aluop;
        logic                   load_cc;
        logic                   load_regfile;
        logic                   sr2mux_sel;
        logic                   mem_read;
        logic                   mem_write;
        // 2'b11 selects the alu result, 2'b01 the memory word
        logic [1:0]             drmux_sel;
    } lc3b_control_word;

    typedef struct packed {
        lc3b_control_word     ctrl;
        lc3b_types::lc3b_reg  dr;
        lc3b_types::lc3b_reg  sr1;
        lc3b_types::lc3b_reg  sr2;
        lc3b_types::lc3b_word imm;
        // byte offset, already shifted left by one
        lc3b_types::lc3b_word offset;
    } queue_entry;

    typedef struct packed {
        lc3b_types::lc3b_reg  dr;
        lc3b_types::lc3b_word data;
    } wb_port;

endpackage

`default_nettype wire

// File: lc3b_slice.f
design/lc3b_types.sv
design/pipe_pkg.sv
design/control_rom.sv
design/decode_stage.sv
design/issue_queue.sv
design/execute_stage.sv
design/lc3b_slice.sv
tests/tb_clock.sv
tests/lc3b_slice_properties.sv
tests/lc3b_slice_tb.sv

// File: tests/lc3b_golden.txt
// columns: test instr wb_expected dr data cc (all hex)
// cc is n/z/p; for lines without writeback it is the cc expected afterwards
1 1225 1 1 0005 1
1 143D 1 2 FFFD 4
1 1620 1 3 0000 2
1 182F 1 4 000F 1
2 1A42 1 5 0002 1
2 5C84 1 6 000D 1
2 5F26 1 7 0006 1
2 9A7F 1 5 FFFA 4
3 DD04 1 6 00F0 1
3 DE94 1 7 0FFF 1
3 DCB1 1 6 FFFE 4
3 DF32 1 7 0003 1
4 7A03 0 0 0000 1
4 7902 0 0 0000 1
4 6603 1 3 FFFA 4
4 6209 1 1 000F 1
4 760A 0 0 0000 1
5 0E05 0 0 0000 1
5 F025 0 0 0000 1
5 4803 0 0 0000 1
5 14E0 1 2 FFFA 4
5 0E05 0 0 0000 4
6 680A 1 4 FFFA 4
6 1B21 1 5 FFFB 4
6 6C03 1 6 FFFA 4
6 5FA7 1 7 0002 1
6 91FF 1 0 FFFD 4
6 1205 1 1 FFF8 4
6 D5C3 1 2 0010 1

// File: tests/lc3b_slice_properties.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_slice_properties (
    input logic       clk,
    input logic       rst_n,
    input logic       instr_valid,
    input logic       full,
    input logic       wb_valid,
    input logic       pop,
    input logic       ldr_wb,
    input logic [2:0] cc
);

    logic seen_wb;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_wb <= 1'b0;
        end else if (wb_valid) begin
            seen_wb <= 1'b1;
        end
    end

    // source must hold off while the queue is full
    no_strobe_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        full |-> !instr_valid)
        else $error("instr_valid strobed while full");

    // a load writes back once, any later writeback needs a fresh pop
    load_wb_single: assert property (@(posedge clk) disable iff (!rst_n)
        ldr_wb |=> wb_valid ##1 (!wb_valid || $past(pop)))
        else $error("load writeback held for more than one cycle");

    cc_onehot0: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(cc))
        else $error("cc has more than one flag set");

    cc_set_after_wb: assert property (@(posedge clk) disable iff (!rst_n)
        (seen_wb || wb_valid) |-> (cc != 3'b000))
        else $error("cc cleared after a writeback");

    cc_zero_before_wb: assert property (@(posedge clk) disable iff (!rst_n)
        (!seen_wb && !wb_valid) |-> (cc == 3'b000))
        else $error("cc set before any writeback");

endmodule

bind lc3b_slice lc3b_slice_properties lc3b_slice_properties_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .full        (full),
    .wb_valid    (wb_valid),
    .pop         (pop),
    .ldr_wb      (execute_stage_i.ldr_wb),
    .cc          (cc)
);

`default_nettype wire

// File: tests/lc3b_slice_tb.sv
`timescale 1ns/1ns
`default_nettype none

module lc3b_slice_tb;

    localparam int max_lines  = 64;
    localparam int cols       = 6;
    // this test strobes back to back with no gaps
    localparam int burst_test = 6;

    logic                  clk;
    logic                  rst_n;
    lc3b_types::lc3b_instr instr;
    logic                  instr_valid;
    logic                  full;
    logic                  wb_valid;
    pipe_pkg::wb_port      wb;
    logic [2:0]            cc;

    logic [15:0] gold [max_lines * cols];
    logic [2:0]  exp_dr [max_lines];
    logic [15:0] exp_data [max_lines];
    logic [2:0]  exp_cc [max_lines];
    int          n_lines;
    int          n_exp;
    int          wb_count;
    int          errors;
    int          seed;
    logic        lines_loaded;

    tb_clock #(.period_ns(10)) tb_clock_i (.clk(clk));

    lc3b_slice lc3b_slice_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .full        (full),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .cc          (cc)
    );

    // words the file does not reach keep this address-based fill
    function automatic logic [15:0] unread_word(input int idx);
        return ~idx[15:0];
    endfunction

    task automatic send_instr(input logic [15:0] word);
        while (full) begin
            @(negedge clk);
        end
        instr       = word;
        instr_valid = 1'b1;
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    // writebacks are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            if (wb_count >= n_exp) begin
                $display("unexpected writeback to r%0d beyond the expected list", wb.dr);
                errors++;
            end else begin
                assert (wb.dr == exp_dr[wb_count])
                    else begin
                        $display("** Error: wb.dr got %h expected %h",
                                 wb.dr, exp_dr[wb_count]);
                        errors++;
                    end
                assert (wb.data == exp_data[wb_count])
                    else begin
                        $display("** Error: wb.data got %h expected %h",
                                 wb.data, exp_data[wb_count]);
                        errors++;
                    end
                assert (cc == exp_cc[wb_count])
                    else begin
                        $display("** Error: cc got %h expected %h",
                                 cc, exp_cc[wb_count]);
                        errors++;
                    end
            end
            wb_count++;
        end
    end

    initial begin
        wait (lines_loaded);
        repeat (n_lines * 40 + 20) @(posedge clk);
        $display("timeout: writebacks stopped arriving before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int          i;
        int          gap;
        int          test_id;
        int          test_errs;
        int          test_wbs;
        int          n_tests;
        int          exp_total;
        logic [2:0]  last_cc;

        instr        = '0;
        instr_valid  = 1'b0;
        rst_n        = 1'b0;
        seed         = 9;
        wb_count     = 0;
        errors       = 0;
        n_lines      = 0;
        n_exp        = 0;
        n_tests      = 0;
        exp_total    = 0;
        lines_loaded = 1'b0;

        for (i = 0; i < max_lines * cols; i++) begin
            gold[i] = unread_word(i);
        end
        $readmemh("tests/lc3b_golden.txt", gold);
        while (n_lines < max_lines &&
               gold[n_lines * cols] != unread_word(n_lines * cols)) begin
            if (gold[n_lines * cols + 2] != 16'h0) begin
                exp_dr[n_exp]   = gold[n_lines * cols + 3][2:0];
                exp_data[n_exp] = gold[n_lines * cols + 4];
                exp_cc[n_exp]   = gold[n_lines * cols + 5][2:0];
                n_exp++;
            end
            n_lines++;
        end
        lines_loaded = 1'b1;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        i = 0;
        while (i < n_lines) begin
            test_id   = gold[i * cols];
            test_errs = errors;
            test_wbs  = wb_count;
            while (i < n_lines && gold[i * cols] == test_id) begin
                if (test_id != burst_test) begin
                    gap = $unsigned($random(seed)) % 4;
                    repeat (gap) @(negedge clk);
                end
                send_instr(gold[i * cols + 1]);
                if (gold[i * cols + 2] != 16'h0) begin
                    exp_total++;
                end
                last_cc = gold[i * cols + 5][2:0];
                i++;
            end
            while (wb_count < exp_total) begin
                @(negedge clk);
            end
            // let no-op entries drain before looking at cc
            repeat (6) @(negedge clk);
            assert (cc == last_cc)
                else begin
                    $display("** Error: cc got %h expected %h", cc, last_cc);
                    errors++;
                end
            // queue is empty once everything has drained
            assert (full == 1'b0)
                else begin
                    $display("** Error: full got %h expected %h", full, 1'b0);
                    errors++;
                end
            n_tests++;
            $display("test %0d done: %0d writebacks, %0d errors",
                     test_id, wb_count - test_wbs, errors - test_errs);
        end

        assert (wb_count == n_exp)
            else begin
                $display("writeback count %0d does not match the %0d expected",
                         wb_count, n_exp);
                errors++;
            end

        $display("tests %0d, writebacks %0d, errors %0d", n_tests, wb_count, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int period_ns = 10
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire
